// File: Bender.yml
package:
  name: a2_card_subsystem

sources:
  - common/a2_card_pkg.sv
  - rtl/scratch_register_card.sv
  - timer_card/timer_card.sv
  - rtl/card_data_arbiter.sv
  - audio/speaker_pulse.sv
  - audio/audio_mixer.sv
  - rtl/a2_card_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_a2_card_top.sv

// File: audio/audio_mixer.sv
// Mixes the speaker pulse and timer tone into registered stereo samples on each audio tick
`timescale 1ns/10ps

module audio_mixer
    import a2_card_pkg::*;
(
    input  logic          clk_pixel_w,
    input  logic          system_reset_n_w,

    input  logic          audio_tick_i,
    input  logic          speaker_level_i,
    input  logic          tone_i,

    output audio_sample_t sample_o,
    output logic          sample_strobe_o
);

    audio_sample_t sample_r;
    logic          sample_strobe_r;
    logic [15:0]   speaker_term_w;
    logic [15:0]   tone_term_w;

    assign speaker_term_w = speaker_level_i ? SPEAKER_LEVEL : 16'h0000;
    assign tone_term_w    = tone_i ? TONE_LEVEL : 16'h0000;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            sample_r        <= '0;
            sample_strobe_r <= 1'b0;
        end else begin
            sample_strobe_r <= audio_tick_i;
            if (audio_tick_i) begin
                // Tone goes to the left channel only
                sample_r.left  <= speaker_term_w + tone_term_w;
                sample_r.right <= speaker_term_w;
            end
        end
    end

    assign sample_o        = sample_r;
    assign sample_strobe_o = sample_strobe_r;

endmodule

// File: audio/speaker_pulse.sv
// Audio tick divider and Apple speaker toggle shaped into a pulse of bounded length
`timescale 1ns/10ps

module speaker_pulse
    import a2_card_pkg::*;
(
    input  logic          clk_pixel_w,
    input  logic          system_reset_n_w,

    input  logic          bus_cycle_strobe_i,
    input  a2_bus_cycle_t bus_cycle_i,

    output logic          audio_tick_o,
    output logic          speaker_level_o
);

    logic [AUDIO_TICK_W-1:0]   tick_cnt_r;
    logic                      audio_tick_r;
    logic                      speaker_bit_r;
    logic                      prev_bit_r;
    logic [SPEAKER_HOLD_W-1:0] hold_r;
    logic                      level_r;
    logic                      speaker_hit_w;

    // Free-running divider, tick is one cycle wide
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            tick_cnt_r   <= '0;
            audio_tick_r <= 1'b0;
        end else begin
            tick_cnt_r   <= tick_cnt_r + 1'b1;
            audio_tick_r <= (tick_cnt_r == AUDIO_TICK_W'(AUDIO_TICK_DIV - 1));
        end
    end

    assign speaker_hit_w = bus_cycle_strobe_i && !bus_cycle_i.m2sel_n &&
                           (bus_cycle_i.addr == SPEAKER_ADDR);

    // A steady speaker level would sit as a DC offset in the HDMI audio,
    // so each toggle only produces a pulse of SPEAKER_HOLD ticks
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            speaker_bit_r <= 1'b0;
            prev_bit_r    <= 1'b0;
            hold_r        <= '0;
            level_r       <= 1'b0;
        end else begin
            if (speaker_hit_w) begin
                speaker_bit_r <= !speaker_bit_r;
            end
            if (audio_tick_r) begin
                prev_bit_r <= speaker_bit_r;
                if (speaker_bit_r != prev_bit_r) begin
                    hold_r <= SPEAKER_HOLD;
                end else if (hold_r != '0) begin
                    hold_r <= hold_r - 1'b1;
                end
                level_r <= prev_bit_r && (hold_r != '0);
            end
        end
    end

    assign audio_tick_o    = audio_tick_r;
    assign speaker_level_o = level_r;

    hold_bounded_a: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        hold_r <= SPEAKER_HOLD
    ) else $error("speaker_pulse: hold counter above SPEAKER_HOLD");

endmodule

// File: common/a2_card_pkg.sv
// Shared bus-cycle, card-response and audio types and constants for the Apple II card subsystem
package a2_card_pkg;

    // One Apple II bus cycle as seen by the card
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        // 1 for a read
        logic        rw_n;
        logic        m2sel_n;
    } a2_bus_cycle_t;

    // A card's answer to a read in its window
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } card_resp_t;

    // One stereo audio sample
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } audio_sample_t;

    // Slot assignment
    localparam int SCRATCH_SLOT = 2;
    localparam int TIMER_SLOT   = 4;

    // Slot I/O space starts at C080, sixteen bytes per slot
    localparam logic [15:0] SLOT_IO_BASE = 16'hC080;
    localparam logic [15:0] SCRATCH_BASE = SLOT_IO_BASE + 16'(SCRATCH_SLOT * 16);
    localparam logic [15:0] TIMER_BASE   = SLOT_IO_BASE + 16'(TIMER_SLOT * 16);

    // Apple speaker soft switch
    localparam logic [15:0] SPEAKER_ADDR = 16'hC030;

    // Clock cycles per audio tick, short for simulation
    localparam int AUDIO_TICK_DIV = 64;
    localparam int AUDIO_TICK_W   = $clog2(AUDIO_TICK_DIV);

    // Speaker pulse length in audio ticks
    localparam int                      SPEAKER_HOLD_W = 4;
    localparam logic [SPEAKER_HOLD_W-1:0] SPEAKER_HOLD   = 4'd15;

    // Sample contributions
    localparam logic [15:0] SPEAKER_LEVEL = 16'h2000;
    localparam logic [15:0] TONE_LEVEL    = 16'h1000;

    // Scratch card register holding the interrupt bit
    localparam logic [3:0] SCRATCH_IRQ_REG = 4'hF;

    // Timer register offsets
    localparam logic [3:0] TMR_RELOAD_LO = 4'd0;
    localparam logic [3:0] TMR_RELOAD_HI = 4'd1;
    localparam logic [3:0] TMR_CTRL      = 4'd2;
    localparam logic [3:0] TMR_STATUS    = 4'd3;

    // Timer control bits
    localparam int CTRL_RUN_BIT     = 0;
    localparam int CTRL_IRQ_EN_BIT  = 1;
    localparam int CTRL_TONE_EN_BIT = 2;
    localparam int CTRL_W           = 3;

endpackage

// File: rtl/a2_card_top.sv
// Card-side bus subsystem top joining the slot cards, data arbiter, speaker and audio mixer
`timescale 1ns/10ps

module a2_card_top
    import a2_card_pkg::*;
(
    input  logic          clk_pixel_w,
    input  logic          system_reset_n_w,

    input  logic          bus_cycle_strobe_i,
    input  a2_bus_cycle_t bus_cycle_i,

    output logic          data_out_en_o,
    output logic [7:0]    data_out_o,
    output logic          irq_n_o,

    output audio_sample_t sample_o,
    output logic          sample_strobe_o
);

    card_resp_t scratch_resp;
    card_resp_t timer_resp;
    logic       scratch_irq_n;
    logic       timer_irq_n;
    logic       tone;
    logic       audio_tick;
    logic       speaker_level;

    // Slot 2
    scratch_register_card scratch_register_card_inst (
        .clk_pixel_w       (clk_pixel_w),
        .system_reset_n_w  (system_reset_n_w),
        .bus_cycle_strobe_i(bus_cycle_strobe_i),
        .bus_cycle_i       (bus_cycle_i),
        .resp_o            (scratch_resp),
        .irq_n_o           (scratch_irq_n)
    );

    // Slot 4
    timer_card timer_card_inst (
        .clk_pixel_w       (clk_pixel_w),
        .system_reset_n_w  (system_reset_n_w),
        .bus_cycle_strobe_i(bus_cycle_strobe_i),
        .bus_cycle_i       (bus_cycle_i),
        .resp_o            (timer_resp),
        .irq_n_o           (timer_irq_n),
        .tone_o            (tone)
    );

    card_data_arbiter card_data_arbiter_inst (
        .clk_pixel_w     (clk_pixel_w),
        .system_reset_n_w(system_reset_n_w),
        .scratch_resp_i  (scratch_resp),
        .timer_resp_i    (timer_resp),
        .scratch_irq_n_i (scratch_irq_n),
        .timer_irq_n_i   (timer_irq_n),
        .data_out_en_o   (data_out_en_o),
        .data_out_o      (data_out_o),
        .irq_n_o         (irq_n_o)
    );

    // Audio path
    speaker_pulse speaker_pulse_inst (
        .clk_pixel_w       (clk_pixel_w),
        .system_reset_n_w  (system_reset_n_w),
        .bus_cycle_strobe_i(bus_cycle_strobe_i),
        .bus_cycle_i       (bus_cycle_i),
        .audio_tick_o      (audio_tick),
        .speaker_level_o   (speaker_level)
    );

    audio_mixer audio_mixer_inst (
        .clk_pixel_w     (clk_pixel_w),
        .system_reset_n_w(system_reset_n_w),
        .audio_tick_i    (audio_tick),
        .speaker_level_i (speaker_level),
        .tone_i          (tone),
        .sample_o        (sample_o),
        .sample_strobe_o (sample_strobe_o)
    );

endmodule

// File: rtl/card_data_arbiter.sv
// Merges card read responses into the registered Apple data-out path and combines card IRQs
`timescale 1ns/10ps

module card_data_arbiter
    import a2_card_pkg::*;
(
    input  logic       clk_pixel_w,
    input  logic       system_reset_n_w,

    input  card_resp_t scratch_resp_i,
    input  card_resp_t timer_resp_i,
    input  logic       scratch_irq_n_i,
    input  logic       timer_irq_n_i,

    output logic       data_out_en_o,
    output logic [7:0] data_out_o,
    output logic       irq_n_o
);

    logic       data_out_en_r;
    logic [7:0] data_out_r;
    logic       irq_n_r;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            data_out_en_r <= 1'b0;
            data_out_r    <= 8'h00;
            irq_n_r       <= 1'b1;
        end else begin
            data_out_en_r <= scratch_resp_i.valid || timer_resp_i.valid;
            // Timer has priority, bus stays at zero when nobody answers
            if (timer_resp_i.valid) begin
                data_out_r <= timer_resp_i.data;
            end else if (scratch_resp_i.valid) begin
                data_out_r <= scratch_resp_i.data;
            end else begin
                data_out_r <= 8'h00;
            end
            // Open-collector style wired AND
            irq_n_r <= scratch_irq_n_i && timer_irq_n_i;
        end
    end

    assign data_out_en_o = data_out_en_r;
    assign data_out_o    = data_out_r;
    assign irq_n_o       = irq_n_r;

    // Slot windows are disjoint, so two cards never answer the same cycle
    one_responder_a: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        !(scratch_resp_i.valid && timer_resp_i.valid)
    ) else $error("card_data_arbiter: two card responses in one cycle");

endmodule

// File: rtl/scratch_register_card.sv
// Slot 2 scratch card with sixteen read/write bytes and an interrupt set by software
`timescale 1ns/10ps

module scratch_register_card
    import a2_card_pkg::*;
(
    input  logic          clk_pixel_w,
    input  logic          system_reset_n_w,

    input  logic          bus_cycle_strobe_i,
    input  a2_bus_cycle_t bus_cycle_i,

    output card_resp_t    resp_o,
    output logic          irq_n_o
);

    logic [15:0][7:0] regs_r;
    card_resp_t       resp_r;
    logic             window_hit_w;
    logic             wr_w;
    logic             rd_w;
    logic [3:0]       offset_w;

    // Window decode C0A0-C0AF
    assign window_hit_w = bus_cycle_strobe_i &&
                          (bus_cycle_i.addr[15:4] == SCRATCH_BASE[15:4]);
    assign offset_w     = bus_cycle_i.addr[3:0];
    assign wr_w         = window_hit_w && !bus_cycle_i.rw_n;
    assign rd_w         = window_hit_w && bus_cycle_i.rw_n;

    // Register file
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            regs_r <= '0;
        end else if (wr_w) begin
            regs_r[offset_w] <= bus_cycle_i.data;
        end
    end

    // Read answer one cycle after the strobe
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            resp_r <= '0;
        end else begin
            resp_r.valid <= rd_w;
            if (rd_w) begin
                resp_r.data <= regs_r[offset_w];
            end else begin
                resp_r.data <= 8'h00;
            end
        end
    end

    assign resp_o = resp_r;

    // Software raises the IRQ via bit 7 of register F
    assign irq_n_o = !regs_r[SCRATCH_IRQ_REG][7];

endmodule

// File: sources.f
+incdir+tb
common/a2_card_pkg.sv
rtl/scratch_register_card.sv
timer_card/timer_card.sv
rtl/card_data_arbiter.sv
audio/speaker_pulse.sv
audio/audio_mixer.sv
rtl/a2_card_top.sv
tb/tb_a2_card_top.sv

// File: tb/a2_card_tasks.svh
// Value check, bus cycle drivers, bounded sample wait and directed tests for the card subsystem
`ifndef A2_CARD_TASKS_SVH
`define A2_CARD_TASKS_SVH

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("Test %s finished with %0d errors", name, error_count - errors_before);
endtask

// Strobe stays high on return so a second call forms a back-to-back pair
task automatic drive_strobe(input logic [15:0] addr, input logic [7:0] data,
                            input logic rw_n, input logic m2sel_n);
    bus_cycle_strobe = 1'b1;
    bus_cycle        = {addr, data, rw_n, m2sel_n};
    @(negedge clk_pixel_w);
endtask

task automatic bus_access(input logic [15:0] addr, input logic [7:0] data,
                          input logic rw_n, input logic m2sel_n);
    drive_strobe(addr, data, rw_n, m2sel_n);
    bus_cycle_strobe = 1'b0;
endtask

// Reads of C000 hit no card and only clock the timer
task automatic idle_strobes(input int count);
    repeat (count) begin
        bus_access(16'hC000, 8'h00, 1'b1, 1'b1);
    end
endtask

// Data shows two cycles after the strobe, for one cycle only
task automatic read_expect(input logic [15:0] addr, input logic [7:0] expected);
    bus_access(addr, 8'h00, 1'b1, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("data_out_en_o", 1, data_out_en);
    compare_value("data_out_o", expected, data_out);
    @(negedge clk_pixel_w);
    compare_value("data_out_en_o", 0, data_out_en);
    compare_value("data_out_o", 0, data_out);
endtask

task automatic await_sample(output audio_sample_t got);
    int waited;
    waited = 0;
    @(negedge clk_pixel_w);
    while (!sample_strobe && waited < 2 * AUDIO_TICK_DIV) begin
        @(negedge clk_pixel_w);
        waited++;
    end
    got = sample_out;
    if (!sample_strobe) begin
        error_count++;
        $display("Timeout: no sample_strobe_o pulse seen by %0t ns", $time);
    end
endtask

task automatic reset_state();
    int errors_before;
    errors_before = error_count;
    repeat (4) begin
        @(negedge clk_pixel_w);
        compare_value("data_out_en_o", 0, data_out_en);
        compare_value("irq_n_o", 1, irq_n);
        compare_value("sample_strobe_o", 0, sample_strobe);
    end
    system_reset_n_w = 1'b1;
    @(negedge clk_pixel_w);
    compare_value("sample_o", 0, sample_out);
    report_test("reset_state", errors_before);
endtask

task automatic scratch_readback();
    logic [7:0]  written [16];
    logic [31:0] rnd;
    int          errors_before;
    errors_before = error_count;
    for (int i = 0; i < 16; i++) begin
        rnd        = $random(seed);
        written[i] = rnd[7:0];
        bus_access(16'hC0A0 + 16'(i), written[i], 1'b0, 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
        read_expect(16'hC0A0 + 16'(i), written[i]);
    end
    // Slot 3 holds no card
    bus_access(16'hC0B0, 8'h00, 1'b1, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("data_out_en_o", 0, data_out_en);
    // Two reads in consecutive cycles
    drive_strobe(16'hC0A3, 8'h00, 1'b1, 1'b1);
    drive_strobe(16'hC0A9, 8'h00, 1'b1, 1'b1);
    bus_cycle_strobe = 1'b0;
    compare_value("data_out_en_o", 1, data_out_en);
    compare_value("data_out_o", written[3], data_out);
    @(negedge clk_pixel_w);
    compare_value("data_out_en_o", 1, data_out_en);
    compare_value("data_out_o", written[9], data_out);
    report_test("scratch_readback", errors_before);
endtask

task automatic scratch_interrupt();
    int errors_before;
    errors_before = error_count;
    // Random fill may have left bit 7 of register F set
    bus_access(16'hC0AF, 8'h00, 1'b0, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("irq_n_o", 1, irq_n);
    bus_access(16'hC0AF, 8'h80, 1'b0, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("irq_n_o", 0, irq_n);
    bus_access(16'hC0AF, 8'h00, 1'b0, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("irq_n_o", 1, irq_n);
    report_test("scratch_interrupt", errors_before);
endtask

task automatic timer_countdown();
    int errors_before;
    errors_before = error_count;
    bus_access(16'hC0C0, 8'h05, 1'b0, 1'b1);
    bus_access(16'hC0C1, 8'h00, 1'b0, 1'b1);
    // Run and IRQ enable with the count starting from 5
    bus_access(16'hC0C2, 8'h03, 1'b0, 1'b1);
    idle_strobes(2);
    // Each read is a strobe too and sees the count before it
    read_expect(16'hC0C0, 8'h03);
    read_expect(16'hC0C1, 8'h00);
    idle_strobes(1);
    compare_value("irq_n_o", 1, irq_n);
    // Count at zero, so this strobe reloads and sets the flag
    idle_strobes(1);
    @(negedge clk_pixel_w);
    compare_value("irq_n_o", 0, irq_n);
    read_expect(16'hC0C3, 8'h01);
    read_expect(16'hC0C0, 8'h04);
    bus_access(16'hC0C3, 8'h00, 1'b0, 1'b1);
    @(negedge clk_pixel_w);
    compare_value("irq_n_o", 1, irq_n);
    // The write that stops the timer still counts once
    bus_access(16'hC0C2, 8'h00, 1'b0, 1'b1);
    read_expect(16'hC0C0, 8'h01);
    report_test("timer_countdown", errors_before);
endtask

task automatic speaker_samples();
    audio_sample_t got;
    int            n;
    int            errors_before;
    errors_before = error_count;
    got           = '0;
    n             = 0;
    bus_access(16'hC030, 8'h00, 1'b1, 1'b0);
    while (got.left != SPEAKER_LEVEL && n < 4) begin
        await_sample(got);
        n++;
    end
    compare_value("sample_o.left", SPEAKER_LEVEL, got.left);
    compare_value("sample_o.right", SPEAKER_LEVEL, got.right);
    n = 0;
    while (got != '0 && n < SPEAKER_HOLD + 2) begin
        await_sample(got);
        n++;
    end
    compare_value("sample_o", 0, got);
    // Toggle back to low gives no pulse
    bus_access(16'hC030, 8'h00, 1'b1, 1'b0);
    repeat (SPEAKER_HOLD + 2) begin
        await_sample(got);
        compare_value("sample_o", 0, got);
    end
    report_test("speaker_samples", errors_before);
endtask

task automatic tone_samples();
    audio_sample_t got;
    logic          tone_exp;
    int            errors_before;
    errors_before = error_count;
    tone_exp      = 1'b0;
    bus_access(16'hC0C0, 8'h03, 1'b0, 1'b1);
    bus_access(16'hC0C1, 8'h00, 1'b0, 1'b1);
    // Run and tone enable
    bus_access(16'hC0C2, 8'h05, 1'b0, 1'b1);
    repeat (4) begin
        // Count 3 down to 0, then an underflow
        idle_strobes(4);
        tone_exp = !tone_exp;
        await_sample(got);
        await_sample(got);
        compare_value("sample_o.left", tone_exp ? TONE_LEVEL : 16'h0000, got.left);
        compare_value("sample_o.right", 0, got.right);
    end
    report_test("tone_samples", errors_before);
endtask

`endif

// File: tb/tb_a2_card_top.sv
// Testbench top driving the Apple II card subsystem through directed bus, timer and audio tests
`timescale 1ns/10ps

module tb_a2_card_top
    import a2_card_pkg::*;
();

    logic          clk_pixel_w = 1'b0;
    logic          system_reset_n_w;
    logic          bus_cycle_strobe;
    a2_bus_cycle_t bus_cycle;
    logic          data_out_en;
    logic [7:0]    data_out;
    logic          irq_n;
    audio_sample_t sample_out;
    logic          sample_strobe;
    integer        seed;
    int            error_count;
    int            check_count;

    a2_card_top a2_card_top_inst (
        .clk_pixel_w       (clk_pixel_w),
        .system_reset_n_w  (system_reset_n_w),
        .bus_cycle_strobe_i(bus_cycle_strobe),
        .bus_cycle_i       (bus_cycle),
        .data_out_en_o     (data_out_en),
        .data_out_o        (data_out),
        .irq_n_o           (irq_n),
        .sample_o          (sample_out),
        .sample_strobe_o   (sample_strobe)
    );

    `include "a2_card_tasks.svh"

    // 4 ns pixel clock
    initial begin
        forever #2 clk_pixel_w = ~clk_pixel_w;
    end

    initial begin
        seed             = 32'h3fe0;
        error_count      = 0;
        check_count      = 0;
        system_reset_n_w = 1'b0;
        bus_cycle_strobe = 1'b0;
        bus_cycle        = '0;

        reset_state();
        scratch_readback();
        scratch_interrupt();
        timer_countdown();
        speaker_samples();
        tone_samples();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: timer_card/timer_card.sv
// Slot 4 countdown timer card clocked by bus strobes, with reload, IRQ and square-wave tone
`timescale 1ns/10ps

module timer_card
    import a2_card_pkg::*;
(
    input  logic          clk_pixel_w,
    input  logic          system_reset_n_w,

    input  logic          bus_cycle_strobe_i,
    input  a2_bus_cycle_t bus_cycle_i,

    output card_resp_t    resp_o,
    output logic          irq_n_o,
    output logic          tone_o
);

    logic [15:0]       reload_r;
    logic [15:0]       count_r;
    logic [CTRL_W-1:0] ctrl_r;
    logic              flag_r;
    logic              tone_r;
    card_resp_t        resp_r;

    logic              window_hit_w;
    logic              wr_w;
    logic              rd_w;
    logic              reload_hi_wr_w;
    logic              underflow_w;
    logic [3:0]        offset_w;
    logic [7:0]        rd_data_w;

    // Window decode C0C0-C0CF
    assign window_hit_w   = bus_cycle_strobe_i &&
                            (bus_cycle_i.addr[15:4] == TIMER_BASE[15:4]);
    assign offset_w       = bus_cycle_i.addr[3:0];
    assign wr_w           = window_hit_w && !bus_cycle_i.rw_n;
    assign rd_w           = window_hit_w && bus_cycle_i.rw_n;
    assign reload_hi_wr_w = wr_w && (offset_w == TMR_RELOAD_HI);

    // A load of the count takes precedence over the countdown
    assign underflow_w = bus_cycle_strobe_i && ctrl_r[CTRL_RUN_BIT] &&
                         (count_r == 16'h0000) && !reload_hi_wr_w;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            reload_r <= 16'h0000;
            count_r  <= 16'h0000;
            ctrl_r   <= '0;
            flag_r   <= 1'b0;
            tone_r   <= 1'b0;
        end else begin
            if (wr_w) begin
                case (offset_w)
                    TMR_RELOAD_LO: reload_r[7:0]  <= bus_cycle_i.data;
                    TMR_RELOAD_HI: reload_r[15:8] <= bus_cycle_i.data;
                    TMR_CTRL:      ctrl_r         <= bus_cycle_i.data[CTRL_W-1:0];
                    TMR_STATUS:    flag_r         <= 1'b0;
                    default:       ;
                endcase
            end
            if (reload_hi_wr_w) begin
                count_r <= {bus_cycle_i.data, reload_r[7:0]};
            end else if (underflow_w) begin
                count_r <= reload_r;
                // Setting the flag wins over a status clear in the same cycle
                flag_r  <= 1'b1;
                if (ctrl_r[CTRL_TONE_EN_BIT]) begin
                    tone_r <= !tone_r;
                end
            end else if (bus_cycle_strobe_i && ctrl_r[CTRL_RUN_BIT]) begin
                count_r <= count_r - 16'd1;
            end
        end
    end

    // Read mux sees the count before this strobe's decrement
    always_comb begin
        case (offset_w)
            TMR_RELOAD_LO: rd_data_w = count_r[7:0];
            TMR_RELOAD_HI: rd_data_w = count_r[15:8];
            TMR_CTRL:      rd_data_w = {{(8 - CTRL_W){1'b0}}, ctrl_r};
            TMR_STATUS:    rd_data_w = {7'b0, flag_r};
            default:       rd_data_w = 8'h00;
        endcase
    end

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            resp_r <= '0;
        end else begin
            resp_r.valid <= rd_w;
            resp_r.data  <= rd_w ? rd_data_w : 8'h00;
        end
    end

    assign resp_o  = resp_r;
    assign irq_n_o = !(flag_r && ctrl_r[CTRL_IRQ_EN_BIT]);
    assign tone_o  = tone_r;

    // Tone edges come only from an underflow one cycle earlier
    tone_after_underflow_a: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        $changed(tone_r) |-> $past(underflow_w)
    ) else $error("timer_card: tone changed without an underflow");

endmodule
